/* source/stats_regs_pkg.sv */
// Port statistics register block
// Shared register map, widths and the APB word address decode

package stats_regs_pkg;

    //////////////////////////////
    // Widths
    //////////////////////////////

    localparam int data_w = 32;
    localparam int addr_w = 12;

    // Word address after the byte offset is dropped
    localparam int word_w = addr_w - 2;

    localparam int port_w = 2;
    localparam int slot_w = 2;

    typedef logic [data_w-1:0] data_t;

    //////////////////////////////
    // Register map
    //////////////////////////////

    // Counter words per port, in slot order
    localparam int slots_per_port = 4;
    localparam int slot_pkt       = 0;
    localparam int slot_byte      = 1;
    localparam int slot_err       = 2;
    localparam int slot_drop      = 3;

    // Control region word indices
    localparam int addr_port_en_con   = 0;
    localparam int addr_port_en_state = 1;
    localparam int addr_params        = 2;
    localparam int addr_cnt_con       = 3;

    localparam int cnt_region_base = 16;
    localparam int cnt_region_id   = cnt_region_base >> (port_w + slot_w);

    // One word address seen as a flat index or as port and slot of a counter
    typedef union packed {
        logic [word_w-1:0] flat;
        struct packed {
            logic [word_w-port_w-slot_w-1:0] region;
            logic [port_w-1:0]               port;
            logic [slot_w-1:0]               slot;
        } cnt;
    } reg_addr_u;

endpackage

/* source/apb_slave_fsm.sv */
// APB access FSM with one fixed wait state
// Drives pready, pslverr and the single-cycle read and write strobes

`timescale 1ns/10ps

module apb_slave_fsm (
    input  logic core_clk_ifc,
    input  logic peripheral_sresetn_core,
    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  logic addr_ok,
    output logic pready,
    output logic pslverr,
    output logic wr_stb,
    output logic rd_stb
);

    // State codes
    localparam logic [1:0] st_idle    = 2'd0;
    localparam logic [1:0] st_wait    = 2'd1;
    localparam logic [1:0] st_respond = 2'd2;

    logic [1:0] state;
    logic [1:0] state_nxt;

    //////////////////////////////
    // Next state
    //////////////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                // Setup phase seen
                if (psel && !penable) begin
                    state_nxt = st_wait;
                end
            end
            st_wait: begin
                if (!psel) begin
                    state_nxt = st_idle;
                end else if (penable) begin
                    state_nxt = st_respond;
                end
            end
            st_respond: begin
                state_nxt = st_idle;
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    //////////////////////////////
    // Outputs
    //////////////////////////////

    // Second access cycle completes the transfer
    assign pready  = (state == st_respond);
    assign pslverr = pready && !addr_ok;
    assign wr_stb  = pready && pwrite;
    assign rd_stb  = pready && !pwrite;

endmodule

/* source/drop_event_counter.sv */
// Buffer-full drop counters, one per port
// Counts rising edges of the drop strobe and restarts at each snapshot

`timescale 1ns/10ps

module drop_event_counter
    import stats_regs_pkg::*;
#(
    parameter int NUM_PORTS = 4
) (
    input  logic                 core_clk_ifc,
    input  logic                 peripheral_sresetn_core,
    input  logic [NUM_PORTS-1:0] buf_full_drop,
    input  logic [NUM_PORTS-1:0] snap_take,
    output data_t                drop_count [NUM_PORTS]
);

    logic [NUM_PORTS-1:0] drop_q;
    logic [NUM_PORTS-1:0] drop_rise;

    assign drop_rise = buf_full_drop & ~drop_q;

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            drop_q <= '0;
            for (int p = 0; p < NUM_PORTS; p++) begin
                drop_count[p] <= '0;
            end
        end else begin
            drop_q <= buf_full_drop;
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (snap_take[p]) begin
                    // Edge in the snapshot cycle belongs to the new period
                    drop_count[p] <= drop_rise[p] ? data_t'(1) : '0;
                end else if (drop_rise[p]) begin
                    drop_count[p] <= drop_count[p] + 1'b1;
                end
            end
        end
    end

endmodule

/* source/snapshot_bank.sv */
// Counter snapshot bank
// Freezes the packet, byte, error and drop counts of a port on request

`timescale 1ns/10ps

module snapshot_bank
    import stats_regs_pkg::*;
#(
    parameter int NUM_PORTS = 4
) (
    input  logic                 core_clk_ifc,
    input  logic                 peripheral_sresetn_core,
    input  logic [NUM_PORTS-1:0] sample_req,
    input  data_t                pkt_count [NUM_PORTS],
    input  data_t                byte_count [NUM_PORTS],
    input  data_t                err_count [NUM_PORTS],
    input  data_t                drop_count [NUM_PORTS],
    output logic [NUM_PORTS-1:0] snap_take,
    input  logic [port_w-1:0]    snap_port,
    input  logic [slot_w-1:0]    snap_slot,
    output data_t                snap_word
);

    logic [NUM_PORTS-1:0] req_q;
    logic [NUM_PORTS-1:0] req_qq;

    data_t frozen [NUM_PORTS][slots_per_port];

    //////////////////////////////
    // Request edge detection
    //////////////////////////////

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            req_q  <= '0;
            req_qq <= '0;
        end else begin
            req_q  <= sample_req;
            req_qq <= req_q;
        end
    end

    // Rising bit of the registered request
    assign snap_take = req_q & ~req_qq;

    //////////////////////////////
    // Frozen words
    //////////////////////////////

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                for (int s = 0; s < slots_per_port; s++) begin
                    frozen[p][s] <= '0;
                end
            end
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (snap_take[p]) begin
                    frozen[p][slot_pkt]  <= pkt_count[p];
                    frozen[p][slot_byte] <= byte_count[p];
                    frozen[p][slot_err]  <= err_count[p];
                    frozen[p][slot_drop] <= drop_count[p];
                end
            end
        end
    end

    // Ports beyond the configured count read as zero
    always_comb begin
        snap_word = '0;
        if (int'(snap_port) < NUM_PORTS) begin
            snap_word = frozen[snap_port][snap_slot];
        end
    end

endmodule

/* source/ctrl_regs.sv */
// Control, state and parameter registers of the statistics block
// Decodes the APB address and selects the read data

`timescale 1ns/10ps

module ctrl_regs
    import stats_regs_pkg::*;
#(
    parameter int NUM_PORTS = 4,
    parameter int MTU_BYTES = 5000
) (
    input  logic                 core_clk_ifc,
    input  logic                 peripheral_sresetn_core,
    input  logic [addr_w-1:0]    paddr,
    input  data_t                pwdata,
    input  logic                 wr_stb,
    input  logic                 rd_stb,
    output logic                 addr_ok,
    output logic [NUM_PORTS-1:0] port_enable,
    output logic [NUM_PORTS-1:0] sample_req,
    output logic [port_w-1:0]    snap_port,
    output logic [slot_w-1:0]    snap_slot,
    input  data_t                snap_word,
    output data_t                prdata
);

    reg_addr_u addr;
    logic      ctrl_hit;
    logic      cnt_hit;
    data_t     params_word;
    data_t     rd_mux;

    logic [NUM_PORTS-1:0] port_enable_con;
    logic [NUM_PORTS-1:0] port_enable_state;
    logic [NUM_PORTS-1:0] cnt_con;

    //////////////////////////////
    // Address decode
    //////////////////////////////

    assign addr     = paddr[addr_w-1:2];
    assign ctrl_hit = addr.flat <= word_w'(addr_cnt_con);
    assign cnt_hit  = (addr.cnt.region == cnt_region_id) && (int'(addr.cnt.port) < NUM_PORTS);
    assign addr_ok  = ctrl_hit || cnt_hit;

    assign snap_port = addr.cnt.port;
    assign snap_slot = addr.cnt.slot;

    //////////////////////////////
    // Registers
    //////////////////////////////

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            port_enable_con   <= '1;
            port_enable_state <= '1;
            cnt_con           <= '0;
        end else begin
            port_enable_state <= port_enable_con;
            // Only the two control words are writable
            if (wr_stb && ctrl_hit) begin
                case (int'(addr.flat))
                    addr_port_en_con: port_enable_con <= pwdata[NUM_PORTS-1:0];
                    addr_cnt_con:     cnt_con         <= pwdata[NUM_PORTS-1:0];
                    default: ;
                endcase
            end
        end
    end

    assign port_enable = port_enable_state;
    assign sample_req  = cnt_con;

    // Port count in the low byte, MTU in the upper half
    assign params_word = {16'(MTU_BYTES), 8'h00, 8'(NUM_PORTS)};

    //////////////////////////////
    // Read data
    //////////////////////////////

    always_comb begin
        rd_mux = '0;
        if (ctrl_hit) begin
            case (int'(addr.flat))
                addr_port_en_con:   rd_mux[NUM_PORTS-1:0] = port_enable_con;
                addr_port_en_state: rd_mux[NUM_PORTS-1:0] = port_enable_state;
                addr_params:        rd_mux = params_word;
                addr_cnt_con:       rd_mux[NUM_PORTS-1:0] = cnt_con;
                default: ;
            endcase
        end else if (cnt_hit) begin
            rd_mux = snap_word;
        end
    end

    // Driven only in the completing read cycle
    assign prdata = rd_stb ? rd_mux : '0;

endmodule

/* source/port_stats_regs.sv */
// Ingress per-port statistics register block on APB
// Port enables, counter snapshots and buffer-full drop counts

`timescale 1ns/10ps

module port_stats_regs
    import stats_regs_pkg::*;
#(
    parameter int NUM_PORTS = 4,
    parameter int MTU_BYTES = 5000
) (
    input  logic                 core_clk_ifc,
    input  logic                 peripheral_sresetn_core,
    // APB slave
    input  logic [addr_w-1:0]    paddr,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  data_t                pwdata,
    output data_t                prdata,
    output logic                 pready,
    output logic                 pslverr,
    // Port side
    output logic [NUM_PORTS-1:0] port_enable,
    input  data_t                pkt_count [NUM_PORTS],
    input  data_t                byte_count [NUM_PORTS],
    input  data_t                err_count [NUM_PORTS],
    input  logic [NUM_PORTS-1:0] buf_full_drop
);

    logic                 wr_stb;
    logic                 rd_stb;
    logic                 addr_ok;
    logic [NUM_PORTS-1:0] sample_req;
    logic [NUM_PORTS-1:0] snap_take;
    logic [port_w-1:0]    snap_port;
    logic [slot_w-1:0]    snap_slot;
    data_t                snap_word;
    data_t                drop_count [NUM_PORTS];

    apb_slave_fsm i_apb_slave_fsm (
        .core_clk_ifc            (core_clk_ifc),
        .peripheral_sresetn_core (peripheral_sresetn_core),
        .psel                    (psel),
        .penable                 (penable),
        .pwrite                  (pwrite),
        .addr_ok                 (addr_ok),
        .pready                  (pready),
        .pslverr                 (pslverr),
        .wr_stb                  (wr_stb),
        .rd_stb                  (rd_stb)
    );

    ctrl_regs #(
        .NUM_PORTS (NUM_PORTS),
        .MTU_BYTES (MTU_BYTES)
    ) i_ctrl_regs (
        .core_clk_ifc            (core_clk_ifc),
        .peripheral_sresetn_core (peripheral_sresetn_core),
        .paddr                   (paddr),
        .pwdata                  (pwdata),
        .wr_stb                  (wr_stb),
        .rd_stb                  (rd_stb),
        .addr_ok                 (addr_ok),
        .port_enable             (port_enable),
        .sample_req              (sample_req),
        .snap_port               (snap_port),
        .snap_slot               (snap_slot),
        .snap_word               (snap_word),
        .prdata                  (prdata)
    );

    snapshot_bank #(
        .NUM_PORTS (NUM_PORTS)
    ) i_snapshot_bank (
        .core_clk_ifc            (core_clk_ifc),
        .peripheral_sresetn_core (peripheral_sresetn_core),
        .sample_req              (sample_req),
        .pkt_count               (pkt_count),
        .byte_count              (byte_count),
        .err_count               (err_count),
        .drop_count              (drop_count),
        .snap_take               (snap_take),
        .snap_port               (snap_port),
        .snap_slot               (snap_slot),
        .snap_word               (snap_word)
    );

    drop_event_counter #(
        .NUM_PORTS (NUM_PORTS)
    ) i_drop_event_counter (
        .core_clk_ifc            (core_clk_ifc),
        .peripheral_sresetn_core (peripheral_sresetn_core),
        .buf_full_drop           (buf_full_drop),
        .snap_take               (snap_take),
        .drop_count              (drop_count)
    );

endmodule

/* test/tb_clock_gen.sv */
// Testbench clock and reset source
// Free running clock, reset held low for a fixed number of cycles

`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int period_ns    = 20,
    parameter int reset_cycles = 3
) (
    output logic core_clk_ifc,
    output logic peripheral_sresetn_core
);

    initial begin
        core_clk_ifc = 1'b0;
        forever begin
            #(period_ns / 2) core_clk_ifc = ~core_clk_ifc;
        end
    end

    // Released on a falling edge, away from the sampling edge
    initial begin
        peripheral_sresetn_core = 1'b0;
        repeat (reset_cycles) @(posedge core_clk_ifc);
        @(negedge core_clk_ifc);
        peripheral_sresetn_core = 1'b1;
    end

endmodule

/* test/port_stats_regs_chk.sv */
// APB protocol and port enable checks for the statistics block

`timescale 1ns/10ps

module port_stats_regs_chk #(
    parameter int NUM_PORTS = 4
) (
    input logic                 core_clk_ifc,
    input logic                 peripheral_sresetn_core,
    input logic                 psel,
    input logic                 penable,
    input logic                 pready,
    input logic                 pslverr,
    input logic [NUM_PORTS-1:0] port_enable
);

    // pready only inside an access phase
    pready_in_access: assert property (@(posedge core_clk_ifc)
        disable iff (!peripheral_sresetn_core) pready |-> (psel && penable))
        else $error("pready seen outside an APB access phase");

    // Error response only on a completing cycle
    pslverr_with_pready: assert property (@(posedge core_clk_ifc)
        disable iff (!peripheral_sresetn_core) pslverr |-> pready)
        else $error("pslverr high without pready");

    // One completion per transfer
    pready_single: assert property (@(posedge core_clk_ifc)
        disable iff (!peripheral_sresetn_core) pready |=> !pready)
        else $error("pready high on two consecutive cycles");

    // All ports enabled as reset ends
    enable_after_reset: assert property (@(posedge core_clk_ifc)
        $rose(peripheral_sresetn_core) |-> (port_enable == '1))
        else $error("port_enable not all ones after reset");

endmodule

/* test/port_stats_regs_tb.sv */
// Testbench for the port statistics register block
// APB master, drop strobes and a register model for the expected reads

`timescale 1ns/10ps

module port_stats_regs_tb
    import stats_regs_pkg::*;
();

    localparam int num_ports     = 4;
    localparam int mtu_bytes     = 5000;
    localparam int num_xfers     = 110;
    localparam int margin_cycles = 250;
    localparam int pready_limit  = 8;

    logic                 core_clk_ifc;
    logic                 peripheral_sresetn_core;
    logic [addr_w-1:0]    paddr;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    data_t                pwdata;
    data_t                prdata;
    logic                 pready;
    logic                 pslverr;
    logic [num_ports-1:0] port_enable;
    data_t                pkt_count [num_ports];
    data_t                byte_count [num_ports];
    data_t                err_count [num_ports];
    logic [num_ports-1:0] buf_full_drop;

    // Register model
    logic [num_ports-1:0] exp_en_con;
    logic [num_ports-1:0] exp_cnt_con;
    data_t                exp_snap [num_ports][slots_per_port];
    data_t                exp_drop [num_ports];

    int    seed;
    int    mismatches;
    int    failures;
    data_t rnd;

    tb_clock_gen #(.period_ns(20), .reset_cycles(3)) i_clock_gen (
        .core_clk_ifc            (core_clk_ifc),
        .peripheral_sresetn_core (peripheral_sresetn_core)
    );

    port_stats_regs #(.NUM_PORTS(num_ports), .MTU_BYTES(mtu_bytes)) i_dut (
        .core_clk_ifc            (core_clk_ifc),
        .peripheral_sresetn_core (peripheral_sresetn_core),
        .paddr                   (paddr),
        .psel                    (psel),
        .penable                 (penable),
        .pwrite                  (pwrite),
        .pwdata                  (pwdata),
        .prdata                  (prdata),
        .pready                  (pready),
        .pslverr                 (pslverr),
        .port_enable             (port_enable),
        .pkt_count               (pkt_count),
        .byte_count              (byte_count),
        .err_count               (err_count),
        .buf_full_drop           (buf_full_drop)
    );

    bind port_stats_regs port_stats_regs_chk #(.NUM_PORTS(NUM_PORTS)) i_chk (
        .core_clk_ifc            (core_clk_ifc),
        .peripheral_sresetn_core (peripheral_sresetn_core),
        .psel                    (psel),
        .penable                 (penable),
        .pready                  (pready),
        .pslverr                 (pslverr),
        .port_enable             (port_enable)
    );

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic check_value(input string name, input data_t expected, input data_t actual);
        assert (actual == expected) else begin
            $display("MISMATCH %s expected %08h actual %08h", name, expected, actual);
            mismatches++;
        end
    endtask

    function automatic logic [addr_w-1:0] cnt_addr(input int port, input int slot);
        return addr_w'((cnt_region_base + port * slots_per_port + slot) * 4);
    endfunction

    // One APB transfer, response checked against the model
    task automatic bus_check(input string name, input logic wr, input logic [addr_w-1:0] addr,
                             input data_t wdata, input data_t exp_data, input logic exp_err);
        int waited;
        waited = 0;
        @(negedge core_clk_ifc);
        paddr   = addr;
        pwrite  = wr;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge core_clk_ifc);
        penable = 1'b1;
        @(negedge core_clk_ifc);
        while (!pready && waited < pready_limit) begin
            waited++;
            @(negedge core_clk_ifc);
        end
        if (!pready) begin
            $display("Transfer %s to address %03h never completed", name, addr);
            failures++;
        end else begin
            check_value({name, " pslverr"}, data_t'(exp_err), data_t'(pslverr));
            if (!wr) begin
                check_value(name, exp_data, prdata);
            end
        end
        // Held through the completing edge
        @(negedge core_clk_ifc);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // Rising control bits freeze that port's counts and restart its drop count
    task automatic set_cnt_con(input logic [num_ports-1:0] mask);
        bus_check("cnt_con write", 1'b1, addr_w'(addr_cnt_con * 4), data_t'(mask), '0, 1'b0);
        for (int p = 0; p < num_ports; p++) begin
            if (mask[p] && !exp_cnt_con[p]) begin
                exp_snap[p][slot_pkt]  = pkt_count[p];
                exp_snap[p][slot_byte] = byte_count[p];
                exp_snap[p][slot_err]  = err_count[p];
                exp_snap[p][slot_drop] = exp_drop[p];
                exp_drop[p] = '0;
            end
        end
        exp_cnt_con = mask;
    endtask

    task automatic check_counters(input string name);
        for (int p = 0; p < num_ports; p++) begin
            for (int s = 0; s < slots_per_port; s++) begin
                bus_check($sformatf("%s port %0d slot %0d", name, p, s), 1'b0, cnt_addr(p, s),
                          '0, exp_snap[p][s], 1'b0);
            end
        end
    endtask

    task automatic new_counts();
        @(negedge core_clk_ifc);
        for (int p = 0; p < num_ports; p++) begin
            pkt_count[p]  = $random(seed);
            byte_count[p] = $random(seed);
            err_count[p]  = $random(seed);
        end
    endtask

    // Port p sees p+1 separated pulses
    task automatic pulse_drops();
        for (int k = 0; k < num_ports; k++) begin
            @(negedge core_clk_ifc);
            for (int p = 0; p < num_ports; p++) begin
                buf_full_drop[p] = (k <= p);
                if (k <= p) begin
                    exp_drop[p]++;
                end
            end
            @(negedge core_clk_ifc);
            buf_full_drop = '0;
        end
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial begin
        seed = 32'hb220ae22;
        mismatches = 0;
        failures = 0;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        buf_full_drop = '0;
        for (int p = 0; p < num_ports; p++) begin
            pkt_count[p] = '0;
            byte_count[p] = '0;
            err_count[p] = '0;
            exp_drop[p] = '0;
            for (int s = 0; s < slots_per_port; s++) begin
                exp_snap[p][s] = '0;
            end
        end
        exp_en_con = '1;
        exp_cnt_con = '0;
        while (!peripheral_sresetn_core) begin
            @(negedge core_clk_ifc);
        end

        // Reset values
        bus_check("reset en_state", 1'b0, addr_w'(addr_port_en_state * 4), '0,
                  data_t'(exp_en_con), 1'b0);
        bus_check("reset en_con", 1'b0, addr_w'(addr_port_en_con * 4), '0,
                  data_t'(exp_en_con), 1'b0);
        bus_check("params", 1'b0, addr_w'(addr_params * 4), '0, (mtu_bytes << 16) | num_ports, 1'b0);
        check_counters("reset");

        // Port enables
        for (int i = 0; i < 4; i++) begin
            rnd = $random(seed);
            bus_check("en_con write", 1'b1, addr_w'(addr_port_en_con * 4), rnd, '0, 1'b0);
            exp_en_con = rnd[num_ports-1:0];
            bus_check("en_con read", 1'b0, addr_w'(addr_port_en_con * 4), '0,
                      data_t'(exp_en_con), 1'b0);
            bus_check("en_state read", 1'b0, addr_w'(addr_port_en_state * 4), '0,
                      data_t'(exp_en_con), 1'b0);
            check_value("port_enable", data_t'(exp_en_con), data_t'(port_enable));
        end

        // Snapshots of live counts
        new_counts();
        set_cnt_con('1);
        check_counters("snap all");
        set_cnt_con('0);
        new_counts();
        rnd = $random(seed);
        set_cnt_con(rnd[num_ports-1:0]);
        check_counters("snap mask");

        // Drop counts, then a period without drops
        pulse_drops();
        set_cnt_con('0);
        set_cnt_con('1);
        check_counters("drops");
        set_cnt_con('0);
        set_cnt_con('1);
        check_counters("no drops");

        // Invalid addresses and the read-only parameters word
        bus_check("beyond counters", 1'b0, 12'h100, '0, '0, 1'b1);
        bus_check("port 4 read", 1'b0, cnt_addr(num_ports, 0), '0, '0, 1'b1);
        bus_check("hole write", 1'b1, 12'h010, $random(seed), '0, 1'b1);
        bus_check("en_con kept", 1'b0, addr_w'(addr_port_en_con * 4), '0,
                  data_t'(exp_en_con), 1'b0);
        bus_check("port 4 write", 1'b1, cnt_addr(num_ports, 1), $random(seed), '0, 1'b1);
        bus_check("params write", 1'b1, addr_w'(addr_params * 4), $random(seed), '0, 1'b0);
        bus_check("params kept", 1'b0, addr_w'(addr_params * 4), '0,
                  (mtu_bytes << 16) | num_ports, 1'b0);

        $display("Checks done: %0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Watchdog sized from the transfer count
    initial begin
        repeat (3 * num_xfers + margin_cycles) @(posedge core_clk_ifc);
        $display("Timeout: the test sequence did not finish in time");
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* list.f */
source/stats_regs_pkg.sv
source/apb_slave_fsm.sv
source/drop_event_counter.sv
source/snapshot_bank.sv
source/ctrl_regs.sv
source/port_stats_regs.sv
test/tb_clock_gen.sv
test/port_stats_regs_chk.sv
test/port_stats_regs_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = port_stats_regs_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)
